/* logic/videoPkg.sv */
//--------------------
// Shared video definitions
// Test pattern select enum
// Pixel and colour widths
// Fixed colour constants
//--------------------
package videoPkg;

	//--------------------
	// Pixel widths
	//--------------------
	// ARGB4444 word
	localparam int cColorDepth = 16;
	// RGB part without alpha
	localparam int cRgbWidth = 12;

	//--------------------
	// Pattern select
	//--------------------
	typedef enum logic [1:0]
	{
		// Eight vertical bars
		patColorBars = 2'd0,
		// Ramp on X and Y
		patGradient  = 2'd1,
		// Flat fill
		patSolid     = 2'd2,
		// 8x8 checkerboard
		patCheckers  = 2'd3
	} patternModeT;

	//--------------------
	// Colour constants
	//--------------------
	// Packed as {blue, green, red}, red in the low nibble
	localparam logic [cRgbWidth-1:0] cSolidColor = 12'h5A3;
	// Fully opaque alpha nibble
	localparam logic [cColorDepth-cRgbWidth-1:0] cAlphaOpaque = 4'hF;

endpackage

/* logic/videoSyncGen.sv */
//--------------------
// Video timing generator
// Wrapping pixel and line counters
// Active-low syncs, data enable
// Active pixel coordinates
//--------------------
`timescale 1ns/1ps

module videoSyncGen #(
	parameter int pHWidth = 11,
	parameter int pVWidth = 11
)(
	input  logic               iVideoClk,
	input  logic               arstN,
	// Timing values, stable between resets
	input  logic [pHWidth-1:0] hDisplay,
	input  logic [pVWidth-1:0] vDisplay,
	input  logic [pHWidth:0]   hSyncStart,
	input  logic [pHWidth:0]   hSyncEnd,
	input  logic [pHWidth:0]   hSyncMax,
	input  logic [pVWidth:0]   vSyncStart,
	input  logic [pVWidth:0]   vSyncEnd,
	input  logic [pVWidth:0]   vSyncMax,
	// Raw timing outputs
	output logic               hSyncRaw,
	output logic               vSyncRaw,
	output logic               deRaw,
	output logic [pHWidth-1:0] pixelX,
	output logic [pVWidth-1:0] pixelY
);

	//--------------------
	// Counter next state
	//--------------------
	logic [pHWidth:0] hCount;
	logic [pHWidth:0] hNext;
	logic [pVWidth:0] vCount;
	logic [pVWidth:0] vNext;
	logic             hWrap;

	always_comb
	begin
		// End of line reached
		hWrap = (hCount == hSyncMax);
		hNext = hWrap ? '0 : hCount + 1'b1;
		// Line counter only moves at the line wrap
		if (!hWrap)
			vNext = vCount;
		else if (vCount == vSyncMax)
			vNext = '0;
		else
			vNext = vCount + 1'b1;
	end

	//--------------------
	// Counters and raw outputs
	//--------------------
	// Outputs decoded from the next count, so they line up with the counter
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hCount   <= '0;
			vCount   <= '0;
			// Syncs idle high
			hSyncRaw <= 1'b1;
			vSyncRaw <= 1'b1;
			// Origin of the frame is inside the active area
			deRaw    <= 1'b1;
		end
		else
		begin
			hCount   <= hNext;
			vCount   <= vNext;
			// Low from start up to but not including end
			hSyncRaw <= !((hNext >= hSyncStart) && (hNext < hSyncEnd));
			vSyncRaw <= !((vNext >= vSyncStart) && (vNext < vSyncEnd));
			// Active window
			deRaw    <= (hNext < {1'b0, hDisplay}) && (vNext < {1'b0, vDisplay});
		end
	end

	// Coordinates, meaningful only while deRaw is high
	assign pixelX = hCount[pHWidth-1:0];
	assign pixelY = vCount[pVWidth-1:0];

	//--------------------
	// Checks
	//--------------------
	// DE must open inside the visible part of a line
	deRiseInActive: assert property (@(posedge iVideoClk) disable iff (!arstN)
		$rose(deRaw) |-> (hCount < {1'b0, hDisplay}));

endmodule

/* logic/videoPatternGen.sv */
//--------------------
// Test pattern pixel generator
// Colour bars, gradient, solid fill, checkers
// One registered ARGB4444 pixel per clock
//--------------------
`timescale 1ns/1ps

module videoPatternGen import videoPkg::*; #(
	parameter int pHWidth = 11,
	parameter int pVWidth = 11
)(
	input  logic                   iVideoClk,
	input  logic                   arstN,
	input  patternModeT            patternMode,
	input  logic [pHWidth-1:0]     pixelX,
	input  logic [pVWidth-1:0]     pixelY,
	output logic [cColorDepth-1:0] argbPixel
);

	// One colour channel
	localparam int nibbleWidth = cRgbWidth / 3;

	logic [nibbleWidth-1:0] red;
	logic [nibbleWidth-1:0] green;
	logic [nibbleWidth-1:0] blue;

	//--------------------
	// Pattern decode
	//--------------------
	always_comb
	begin
		red   = '0;
		green = '0;
		blue  = '0;
		case (patternMode)
			patColorBars:
			begin
				// Bar index from X bits 6..4, each channel full on or off
				red   = {nibbleWidth{pixelX[6]}};
				green = {nibbleWidth{pixelX[5]}};
				blue  = {nibbleWidth{pixelX[4]}};
			end
			patGradient:
			begin
				red   = pixelX[7:4];
				green = pixelY[7:4];
				// Fine texture from the low nibbles
				blue  = pixelX[3:0] ^ pixelY[3:0];
			end
			patSolid:
			begin
				{blue, green, red} = cSolidColor;
			end
			patCheckers:
			begin
				// White where the 8-pixel cells differ
				red   = {nibbleWidth{pixelX[3] ^ pixelY[3]}};
				green = red;
				blue  = red;
			end
		endcase
	end

	//--------------------
	// Pixel register
	//--------------------
	// One cycle after the coordinate
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			argbPixel <= '0;
		else
			argbPixel <= {cAlphaOpaque, blue, green, red};
	end

endmodule

/* logic/videoOutStage.sv */
//--------------------
// Panel output stage
// Sync and DE alignment delay
// Alpha removal and colour blanking
// Registered panel pins
//--------------------
`timescale 1ns/1ps

module videoOutStage import videoPkg::*; (
	input  logic                     iVideoClk,
	input  logic                     arstN,
	input  logic [cColorDepth-1:0]   argbPixel,
	input  logic                     hSyncRaw,
	input  logic                     vSyncRaw,
	input  logic                     deRaw,
	output logic [cRgbWidth/3-1:0]   tftColorR,
	output logic [cRgbWidth/3-1:0]   tftColorG,
	output logic [cRgbWidth/3-1:0]   tftColorB,
	output logic                     tftHSync,
	output logic                     tftVSync,
	output logic                     tftDe
);

	localparam int nibbleWidth = cRgbWidth / 3;

	// Alpha nibble dropped here
	logic [cRgbWidth-1:0] rgb;
	logic                 hSyncDly;
	logic                 vSyncDly;
	logic                 deDly;

	assign rgb = argbPixel[cRgbWidth-1:0];

	//--------------------
	// Alignment and pins
	//--------------------
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hSyncDly  <= 1'b1;
			vSyncDly  <= 1'b1;
			deDly     <= 1'b0;
			// Panel idle: syncs high, DE low, black
			tftHSync  <= 1'b1;
			tftVSync  <= 1'b1;
			tftDe     <= 1'b0;
			tftColorR <= '0;
			tftColorG <= '0;
			tftColorB <= '0;
		end
		else
		begin
			// Matches the pattern generator latency
			hSyncDly  <= hSyncRaw;
			vSyncDly  <= vSyncRaw;
			deDly     <= deRaw;
			tftHSync  <= hSyncDly;
			tftVSync  <= vSyncDly;
			tftDe     <= deDly;
			// Red sits in the low nibble
			tftColorR <= deDly ? rgb[nibbleWidth-1:0] : '0;
			tftColorG <= deDly ? rgb[2*nibbleWidth-1:nibbleWidth] : '0;
			tftColorB <= deDly ? rgb[3*nibbleWidth-1:2*nibbleWidth] : '0;
		end
	end

	// Black outside the active window
	blankOutsideDe: assert property (@(posedge iVideoClk) disable iff (!arstN)
		!tftDe |-> ({tftColorB, tftColorG, tftColorR} == '0));

endmodule

/* logic/backlightPwm.sv */
//--------------------
// Backlight dimmer
// Free-running 8-bit PWM
//--------------------
`timescale 1ns/1ps

module backlightPwm (
	input  logic       iVideoClk,
	input  logic       arstN,
	// High cycles out of every 256
	input  logic [7:0] blDuty,
	output logic       tftBackLight
);

	//--------------------
	// Period counter
	//--------------------
	logic [7:0] pwmCount;

	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			pwmCount <= '0;
		else
			// Wraps naturally every 256 cycles
			pwmCount <= pwmCount + 8'd1;
	end

	//--------------------
	// Duty compare
	//--------------------
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			tftBackLight <= 1'b0;
		else
			// Registered so the pin stays glitch free
			tftBackLight <= (pwmCount < blDuty);
	end

	// Zero duty keeps the backlight fully off
	darkAtZeroDuty: assert property (@(posedge iVideoClk) disable iff (!arstN)
		($past(blDuty) == 8'd0) |-> !tftBackLight);

endmodule

/* logic/videoTxUnit.sv */
//--------------------
// TFT video transmit top
// Timing, pattern and output stages
// Backlight PWM, clock and reset pass-through
//--------------------
`timescale 1ns/1ps

module videoTxUnit import videoPkg::*; #(
	parameter int pHWidth = 11,
	parameter int pVWidth = 11
)(
	input  logic                   iVideoClk,
	input  logic                   arstN,
	// Panel timing
	input  logic [pHWidth-1:0]     hDisplay,
	input  logic [pVWidth-1:0]     vDisplay,
	input  logic [pHWidth:0]       hSyncStart,
	input  logic [pHWidth:0]       hSyncEnd,
	input  logic [pHWidth:0]       hSyncMax,
	input  logic [pVWidth:0]       vSyncStart,
	input  logic [pVWidth:0]       vSyncEnd,
	input  logic [pVWidth:0]       vSyncMax,
	// Control
	input  patternModeT            patternMode,
	input  logic [7:0]             blDuty,
	input  logic                   displayRst,
	// Panel pins
	output logic [cRgbWidth/3-1:0] tftColorR,
	output logic [cRgbWidth/3-1:0] tftColorG,
	output logic [cRgbWidth/3-1:0] tftColorB,
	output logic                   tftDclk,
	output logic                   tftHSync,
	output logic                   tftVSync,
	output logic                   tftDe,
	output logic                   tftBackLight,
	output logic                   tftRst
);

	logic                   hSyncRaw;
	logic                   vSyncRaw;
	logic                   deRaw;
	logic [pHWidth-1:0]     pixelX;
	logic [pVWidth-1:0]     pixelY;
	logic [cColorDepth-1:0] argbPixel;

	//--------------------
	// Timing generator
	//--------------------
	videoSyncGen #(
		.pHWidth    (pHWidth),
		.pVWidth    (pVWidth)
	) syncGen (
		.iVideoClk  (iVideoClk),
		.arstN      (arstN),
		.hDisplay   (hDisplay),
		.vDisplay   (vDisplay),
		.hSyncStart (hSyncStart),
		.hSyncEnd   (hSyncEnd),
		.hSyncMax   (hSyncMax),
		.vSyncStart (vSyncStart),
		.vSyncEnd   (vSyncEnd),
		.vSyncMax   (vSyncMax),
		.hSyncRaw   (hSyncRaw),
		.vSyncRaw   (vSyncRaw),
		.deRaw      (deRaw),
		.pixelX     (pixelX),
		.pixelY     (pixelY)
	);

	//--------------------
	// Pixel source and pins
	//--------------------
	videoPatternGen #(
		.pHWidth     (pHWidth),
		.pVWidth     (pVWidth)
	) patternGen (
		.iVideoClk   (iVideoClk),
		.arstN       (arstN),
		.patternMode (patternMode),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.argbPixel   (argbPixel)
	);

	// Two cycles from counter state to the pins
	videoOutStage outStage (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.argbPixel (argbPixel),
		.hSyncRaw  (hSyncRaw),
		.vSyncRaw  (vSyncRaw),
		.deRaw     (deRaw),
		.tftColorR (tftColorR),
		.tftColorG (tftColorG),
		.tftColorB (tftColorB),
		.tftHSync  (tftHSync),
		.tftVSync  (tftVSync),
		.tftDe     (tftDe)
	);

	// Backlight runs beside the pipeline
	backlightPwm blPwm (
		.iVideoClk    (iVideoClk),
		.arstN        (arstN),
		.blDuty       (blDuty),
		.tftBackLight (tftBackLight)
	);

	// Pixel clock and panel reset go straight out
	assign tftDclk = iVideoClk;
	assign tftRst  = displayRst;

endmodule

/* verification/videoTxUnitTb.sv */
//--------------------
// Testbench for the video transmit top
// Row table of timing, pattern and duty
// Frame monitor with pixel and sync models
// Watchdog and result reporting
//--------------------
`timescale 1ns/1ps

module videoTxUnitTb import videoPkg::*;;

	localparam int cHWidth = 11;
	localparam int cVWidth = 11;
	localparam int cRows = 5;
	localparam int cResetCycles = 8;

	// One test row in pixel and line units
	typedef struct packed
	{
		int          hDisp;
		int          hMax;
		int          vDisp;
		int          vStart;
		int          vEnd;
		int          vMax;
		patternModeT mode;
		int          duty;
		int          rst;
	} rowT;

	logic                 iVideoClk;
	logic                 arstN;
	logic [cHWidth-1:0]   hDisplay;
	logic [cVWidth-1:0]   vDisplay;
	logic [cHWidth:0]     hSyncStart;
	logic [cHWidth:0]     hSyncEnd;
	logic [cHWidth:0]     hSyncMax;
	logic [cVWidth:0]     vSyncStart;
	logic [cVWidth:0]     vSyncEnd;
	logic [cVWidth:0]     vSyncMax;
	patternModeT          patternMode;
	logic [7:0]           blDuty;
	logic                 displayRst;
	logic [3:0]           tftColorR;
	logic [3:0]           tftColorG;
	logic [3:0]           tftColorB;
	logic                 tftDclk;
	logic                 tftHSync;
	logic                 tftVSync;
	logic                 tftDe;
	logic                 tftBackLight;
	logic                 tftRst;

	rowT rowTable [cRows];
	int  seed = 32'h5e152b95;
	int  curHStart;
	int  curHEnd;
	int  checkCount;
	int  errorCount;
	int  rowErrors;
	int  cycleCount = 0;
	int  cycleLimit;

	videoTxUnit #(
		.pHWidth (cHWidth),
		.pVWidth (cVWidth)
	) uut (.*);

	//--------------------
	// Clock and watchdog
	//--------------------
	initial
	begin
		iVideoClk = 1'b0;
		forever
			#4 iVideoClk = ~iVideoClk;
	end

	always @(posedge iVideoClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("Timeout: run went past %0d cycles without finishing", cycleLimit);
			$display("Checks failed");
			$finish;
		end
	end

	//--------------------
	// Models and checks
	//--------------------
	// Panel colour for one coordinate packed as {blue, green, red}
	function automatic logic [11:0] expectedRgb(patternModeT mode, int x, int y);
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		r = 4'h0;
		g = 4'h0;
		b = 4'h0;
		if (mode == patColorBars)
		begin
			r = x[6] ? 4'hF : 4'h0;
			g = x[5] ? 4'hF : 4'h0;
			b = x[4] ? 4'hF : 4'h0;
		end
		else if (mode == patGradient)
		begin
			r = x[7:4];
			g = y[7:4];
			b = x[3:0] ^ y[3:0];
		end
		else if (mode == patSolid)
			{b, g, r} = cSolidColor;
		else if (x[3] != y[3])
			{b, g, r} = 12'hFFF;
		return {b, g, r};
	endfunction

	task automatic checkValue(input string name, input int expVal, input int actVal);
		checkCount++;
		if (expVal != actVal)
		begin
			errorCount++;
			rowErrors++;
			$display("error %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal,
				$time);
		end
	endtask

	// Watchdog limit of twice the whole run length
	function automatic int cycleLimitFor();
		int total;
		total = 0;
		for (int r = 0; r < cRows; r++)
			total += 2 * (rowTable[r].hMax + 1) * (rowTable[r].vMax + 1) + 256 + cResetCycles;
		return total * 2;
	endfunction

	//--------------------
	// Reset and row setup
	//--------------------
	task automatic resetDut(input int r);
		int rnd;
		rnd = $random(seed);
		// Hsync inside the blanking and 2 to 7 cycles long
		curHStart = rowTable[r].hDisp + 1 + (rnd & 7);
		curHEnd = curHStart + 2 + (((rnd >> 8) & 255) % 6);
		@(posedge iVideoClk);
		#1;
		arstN = 1'b0;
		hDisplay = cHWidth'(rowTable[r].hDisp);
		vDisplay = cVWidth'(rowTable[r].vDisp);
		hSyncStart = (cHWidth + 1)'(curHStart);
		hSyncEnd = (cHWidth + 1)'(curHEnd);
		hSyncMax = (cHWidth + 1)'(rowTable[r].hMax);
		vSyncStart = (cVWidth + 1)'(rowTable[r].vStart);
		vSyncEnd = (cVWidth + 1)'(rowTable[r].vEnd);
		vSyncMax = (cVWidth + 1)'(rowTable[r].vMax);
		patternMode = rowTable[r].mode;
		blDuty = 8'(rowTable[r].duty);
		displayRst = (rowTable[r].rst != 0);
		repeat (cResetCycles) @(posedge iVideoClk);
		#2;
		// Idle panel while reset is held
		checkValue("tftHSync", 1, int'(tftHSync));
		checkValue("tftVSync", 1, int'(tftVSync));
		checkValue("tftDe", 0, int'(tftDe));
		checkValue("tftColorBGR", 0, int'({tftColorB, tftColorG, tftColorR}));
		checkValue("tftBackLight", 0, int'(tftBackLight));
		checkValue("tftRst", rowTable[r].rst, int'(tftRst));
		// Clock high now and low 3 ns later
		checkValue("tftDclk", 1, int'(tftDclk));
		#3;
		checkValue("tftDclk", 0, int'(tftDclk));
		@(posedge iVideoClk);
		#1;
		arstN = 1'b1;
	endtask

	//--------------------
	// Frame monitor
	//--------------------
	task automatic runRow(input int r);
		rowT        row;
		int         nCycles;
		int         x;
		int         y;
		int         deRun;
		int         lineCount;
		int         frames;
		int         hLow;
		int         vLow;
		int         blSum;
		int         idx;
		bit         blHist [256];
		logic       prevDe;
		logic       prevH;
		logic       prevV;
		logic [11:0] exp;
		row = rowTable[r];
		nCycles = 2 * (row.hMax + 1) * (row.vMax + 1);
		x = 0;
		y = 0;
		deRun = 0;
		lineCount = 0;
		frames = 0;
		hLow = 0;
		vLow = 0;
		blSum = 0;
		prevDe = 1'b0;
		prevH = 1'b1;
		prevV = 1'b1;
		for (int i = 0; i < nCycles; i++)
		begin
			@(posedge iVideoClk);
			#2;
			if (tftDe)
			begin
				exp = expectedRgb(row.mode, x, y);
				checkValue("tftColorR", int'(exp[3:0]), int'(tftColorR));
				checkValue("tftColorG", int'(exp[7:4]), int'(tftColorG));
				checkValue("tftColorB", int'(exp[11:8]), int'(tftColorB));
				x++;
				deRun++;
			end
			else
			begin
				checkValue("tftColorBGR", 0, int'({tftColorB, tftColorG, tftColorR}));
				// Falling DE closes a line
				if (prevDe)
				begin
					checkValue("tftDe run", row.hDisp, deRun);
					deRun = 0;
					x = 0;
					y++;
					lineCount++;
				end
			end
			// Hsync pulse width
			if (!tftHSync)
				hLow++;
			else if (!prevH)
			begin
				checkValue("tftHSync low", curHEnd - curHStart, hLow);
				hLow = 0;
			end
			// Vsync fall ends a frame
			if (!tftVSync)
			begin
				if (prevV)
				begin
					checkValue("tftDe lines", row.vDisp, lineCount);
					frames++;
					lineCount = 0;
					y = 0;
				end
				vLow++;
			end
			else if (!prevV)
			begin
				checkValue("tftVSync low", (row.vEnd - row.vStart) * (row.hMax + 1), vLow);
				vLow = 0;
			end
			// Sliding 256-cycle window over the backlight
			idx = i % 256;
			blSum = blSum + int'(tftBackLight) - int'(blHist[idx]);
			blHist[idx] = tftBackLight;
			if (i >= 255)
				checkValue("tftBackLight high", row.duty, blSum);
			checkValue("tftRst", row.rst, int'(tftRst));
			prevDe = tftDe;
			prevH = tftHSync;
			prevV = tftVSync;
		end
		checkValue("tftVSync frames", 2, frames);
	endtask

	//--------------------
	// Main sequence
	//--------------------
	initial
	begin
		patternModeT mode;
		arstN = 1'b0;
		hDisplay = '0;
		vDisplay = '0;
		hSyncStart = '0;
		hSyncEnd = '0;
		hSyncMax = '0;
		vSyncStart = '0;
		vSyncEnd = '0;
		vSyncMax = '0;
		patternMode = patColorBars;
		blDuty = '0;
		displayRst = 1'b0;
		checkCount = 0;
		errorCount = 0;
		// hDisp, hMax, vDisp, vStart, vEnd, vMax, mode, duty, displayRst
		rowTable[0] = '{40, 59, 12, 13, 15, 17, patColorBars, 0, 0};
		rowTable[1] = '{40, 59, 20, 21, 23, 25, patGradient, 64, 1};
		rowTable[2] = '{130, 149, 6, 7, 8, 9, patColorBars, 200, 0};
		rowTable[3] = '{24, 43, 20, 21, 23, 25, patCheckers, 255, 1};
		rowTable[4] = '{32, 51, 10, 11, 12, 14, patSolid, 128, 0};
		cycleLimit = cycleLimitFor();
		for (int r = 0; r < cRows; r++)
		begin
			rowErrors = 0;
			mode = rowTable[r].mode;
			resetDut(r);
			runRow(r);
			$display("Row %0d %s duty %0d hsync %0d..%0d: %0d errors", r, mode.name(),
				rowTable[r].duty, curHStart, curHEnd, rowErrors);
		end
		$display("Rows %0d, checks %0d, errors %0d", cRows, checkCount, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* files.f */
logic/videoPkg.sv
logic/videoSyncGen.sv
logic/videoPatternGen.sv
logic/videoOutStage.sv
logic/backlightPwm.sv
logic/videoTxUnit.sv
verification/videoTxUnitTb.sv

/* Makefile */
# Verilator build and run for the video transmit testbench

VERILATOR ?= verilator
TOP       ?= videoTxUnitTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

# Sources read from the file list so edits trigger a rebuild
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
